// ==== hdl/clocks_resets.sv ====
`timescale 1ns/100ps

module clocks_resets (
    input  logic i_brd_clk_p,
    input  logic i_brd_rst,
    input  logic i_ddr_calib_done,
    output logic o_sys_rst,
    output logic o_sys_clk,
    output logic o_clk_200
);

    // Status between the clock model and the reset controller
    crg_if u_crg ();

    // ====================
    // Clock generation
    // ====================
    pll_model u_pll_model (
        .i_brd_clk_p (i_brd_clk_p),
        .i_brd_rst   (i_brd_rst),
        .crg         (u_crg.src),
        .o_sys_clk   (o_sys_clk)
    );

    // ====================
    // Reset generation
    // ====================
    reset_ctrl u_reset_ctrl (
        .i_brd_clk_p      (i_brd_clk_p),
        .i_brd_rst        (i_brd_rst),
        .i_ddr_calib_done (i_ddr_calib_done),
        .crg              (u_crg.ctrl),
        .o_sys_rst        (o_sys_rst)
    );

    // Board clock goes out as is
    assign o_clk_200 = i_brd_clk_p;

endmodule

// ==== hdl/crg_if.sv ====
`timescale 1ns/100ps

// Internal status between the clock model and the reset controller
interface crg_if;

    logic pll_locked;   // Lock flag from the PLL model
    logic sys_clk_en;   // One board cycle per system period
    logic rst_tmp;      // Board reset or not yet locked
    logic calib_sync;   // Calibration flag after the sync chain
    logic sys_rst;      // Registered system reset

    // Clock side
    modport src (
        output pll_locked,
        output sys_clk_en,
        input  rst_tmp
    );

    // Reset side
    modport ctrl (
        input  pll_locked,
        input  sys_clk_en,
        output rst_tmp,
        output calib_sync,
        output sys_rst
    );

endinterface

// ==== hdl/crg_state_pkg.sv ====
package crg_state_pkg;

    // Lock timer states
    typedef enum logic [1:0] {
        LK_RESET  = 2'd0,   // Just out of board reset
        LK_COUNT  = 2'd1,   // Waiting for the lock delay
        LK_LOCKED = 2'd2    // PLL output usable
    } lock_state_e;

    // Reset sequencer states
    typedef enum logic [1:0] {
        RS_HOLD       = 2'd0,   // Stretched reset still draining
        RS_WAIT_CALIB = 2'd1,   // Waiting for DDR calibration
        RS_RUN        = 2'd2    // System reset released
    } rst_state_e;

endpackage

// ==== hdl/crg_timing_pkg.sv ====
package crg_timing_pkg;

    // ====================
    // System clock
    // ====================

    // Board cycles per system clock period
    // Must be even
    localparam int SYS_CLK_DIV = 4;

    // ====================
    // Lock and reset
    // ====================

    // Board cycles from board reset release to PLL lock
    localparam int LOCK_CYCLES = 20;

    // Stages in both synchronizer chains
    // Each stage advances once per system clock enable
    localparam int RST_SYNC_NUM = 8;

endpackage

// ==== hdl/pll_model.sv ====
`timescale 1ns/100ps

module pll_model (
    input  logic i_brd_clk_p,
    input  logic i_brd_rst,
    crg_if.src   crg,
    output logic o_sys_clk
);
    import crg_timing_pkg::*;
    import crg_state_pkg::*;

    localparam int HALF_DIV = SYS_CLK_DIV / 2;
    localparam int LOCK_W   = $clog2(LOCK_CYCLES);
    localparam int DIV_W    = (HALF_DIV > 1) ? $clog2(HALF_DIV) : 1;

    lock_state_e       lock_state;
    logic [LOCK_W-1:0] lock_cnt;
    logic              pll_locked;
    logic [DIV_W-1:0]  div_cnt;
    logic              div_wrap;
    logic              sys_clk;
    logic              sys_clk_en;

    // ====================
    // Lock timer
    // ====================
    always_ff @(posedge i_brd_clk_p or posedge i_brd_rst)
    begin
        if (i_brd_rst)
        begin
            lock_state <= LK_RESET;
            lock_cnt   <= '0;
            pll_locked <= 1'b0;
        end
        else
        begin
            case (lock_state)
                LK_RESET:
                begin
                    lock_state <= LK_COUNT;
                    lock_cnt   <= LOCK_W'(1);   // First cycle after release
                end
                LK_COUNT:
                begin
                    if (lock_cnt == LOCK_W'(LOCK_CYCLES - 1))
                    begin
                        lock_state <= LK_LOCKED;
                        pll_locked <= 1'b1;
                    end
                    else
                        lock_cnt <= lock_cnt + LOCK_W'(1);
                end
                LK_LOCKED:
                    pll_locked <= 1'b1;         // Stays locked until board reset
                default:
                    lock_state <= LK_RESET;
            endcase
        end
    end

    // ====================
    // System clock divider
    // ====================
    assign div_wrap = (div_cnt == DIV_W'(HALF_DIV - 1));

    always_ff @(posedge i_brd_clk_p or posedge i_brd_rst)
    begin
        if (i_brd_rst)
        begin
            div_cnt    <= '0;
            sys_clk    <= 1'b0;
            sys_clk_en <= 1'b0;
        end
        else if (crg.rst_tmp)   // No output before lock
        begin
            div_cnt    <= '0;
            sys_clk    <= 1'b0;
            sys_clk_en <= 1'b0;
        end
        else
        begin
            sys_clk_en <= div_wrap & ~sys_clk;   // Goes high with the rising edge
            if (div_wrap)
            begin
                div_cnt <= '0;
                sys_clk <= ~sys_clk;
            end
            else
                div_cnt <= div_cnt + DIV_W'(1);
        end
    end

    assign crg.pll_locked = pll_locked;
    assign crg.sys_clk_en = sys_clk_en;
    assign o_sys_clk      = sys_clk;

endmodule

// ==== hdl/reset_ctrl.sv ====
`timescale 1ns/100ps

module reset_ctrl (
    input  logic i_brd_clk_p,
    input  logic i_brd_rst,
    input  logic i_ddr_calib_done,
    crg_if.ctrl  crg,
    output logic o_sys_rst
);
    import crg_timing_pkg::*;
    import crg_state_pkg::*;

    logic       rst_tmp;
    logic       rst_chain_q;    // Stretched reset that drops once drained
    logic       calib_sync;
    rst_state_e rst_state;
    rst_state_e rst_state_nxt;
    logic       sys_rst;

    // Held in reset until the PLL reports lock
    assign rst_tmp = i_brd_rst | ~crg.pll_locked;

    // ====================
    // Synchronizer chains
    // ====================
    sync_chain #(
        .DEPTH     (RST_SYNC_NUM),
        .RESET_VAL (1'b1)
    ) u_rst_chain (
        .i_brd_clk_p (i_brd_clk_p),
        .i_rst_tmp   (rst_tmp),
        .i_en        (crg.sys_clk_en),
        .i_d         (1'b0),            // Zeros shift in after release
        .o_q         (rst_chain_q)
    );

    sync_chain #(
        .DEPTH     (RST_SYNC_NUM),
        .RESET_VAL (1'b0)
    ) u_calib_chain (
        .i_brd_clk_p (i_brd_clk_p),
        .i_rst_tmp   (rst_tmp),
        .i_en        (crg.sys_clk_en),
        .i_d         (i_ddr_calib_done),
        .o_q         (calib_sync)
    );

    // ====================
    // Release sequencer
    // ====================
    always_comb
    begin
        rst_state_nxt = rst_state;
        case (rst_state)
            RS_HOLD:
                if (!rst_chain_q)
                    rst_state_nxt = RS_WAIT_CALIB;
            RS_WAIT_CALIB:
                if (calib_sync)
                    rst_state_nxt = RS_RUN;
            RS_RUN:
                if (!calib_sync)
                    rst_state_nxt = RS_WAIT_CALIB;  // Calibration lost
            default:
                rst_state_nxt = RS_HOLD;
        endcase
    end

    always_ff @(posedge i_brd_clk_p or posedge rst_tmp)
    begin
        if (rst_tmp)
        begin
            rst_state <= RS_HOLD;
            sys_rst   <= 1'b1;
        end
        else
        begin
            rst_state <= rst_state_nxt;
            sys_rst   <= (rst_state_nxt != RS_RUN);   // Tracks the state register
        end
    end

    assign crg.rst_tmp    = rst_tmp;
    assign crg.calib_sync = calib_sync;
    assign crg.sys_rst    = sys_rst;
    assign o_sys_rst      = sys_rst;

endmodule

// ==== hdl/sync_chain.sv ====
`timescale 1ns/100ps

// Shift register that steps only on the system clock enable
module sync_chain #(
    parameter int DEPTH     = 2,
    parameter bit RESET_VAL = 1'b0
) (
    input  logic i_brd_clk_p,
    input  logic i_rst_tmp,
    input  logic i_en,
    input  logic i_d,
    output logic o_q
);

    logic [DEPTH-1:0] stages;

    always_ff @(posedge i_brd_clk_p or posedge i_rst_tmp)
    begin
        if (i_rst_tmp)
            stages <= {DEPTH{RESET_VAL}};           // Whole chain preset or cleared
        else if (i_en)
            stages <= {stages[DEPTH-2:0], i_d};     // New bit enters at the bottom
    end

    // Oldest bit leaves at the top
    assign o_q = stages[DEPTH-1];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the clock and reset testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_clocks_resets -f verilog.f

# The run status is judged from the log below
./obj_dir/Vtb_clocks_resets > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

if ! grep -q "TB PASSED" sim.log; then
    echo "Simulation ended without a pass result"
    exit 1
fi

exit 0

// ==== tests/crg_chk.sv ====
`timescale 1ns/100ps

// Bound into reset_ctrl
module crg_chk (
    input logic i_brd_clk_p,
    input logic i_rst_tmp,
    input logic i_sys_clk_en,
    input logic i_calib_sync,
    input logic i_sys_rst
);
    import crg_timing_pkg::*;

    logic [7:0] en_gap;     // Board cycles since the last enable
    logic       en_seen;    // At least one enable since reset

    always_ff @(posedge i_brd_clk_p or posedge i_rst_tmp)
    begin
        if (i_rst_tmp)
        begin
            en_gap  <= '0;
            en_seen <= 1'b0;
        end
        else if (i_sys_clk_en)
        begin
            en_gap  <= 8'd1;
            en_seen <= 1'b1;
        end
        else if (en_gap != 8'hff)
            en_gap <= en_gap + 8'd1;    // Saturates
    end

    // ====================
    // Reset behavior
    // ====================
    a_rst_cover: assert property (@(posedge i_brd_clk_p) i_rst_tmp |-> i_sys_rst)
        else $error("sys_rst low while rst_tmp is high");

    a_release_calib: assert property (@(posedge i_brd_clk_p) $fell(i_sys_rst) |-> i_calib_sync)
        else $error("sys_rst released without calibration");

    // ====================
    // Enable spacing
    // ====================
    a_en_spacing: assert property (@(posedge i_brd_clk_p) disable iff (i_rst_tmp)
        (i_sys_clk_en && en_seen) |-> (en_gap == 8'(SYS_CLK_DIV)))
        else $error("sys_clk_en pulse came early");

    a_en_missing: assert property (@(posedge i_brd_clk_p) disable iff (i_rst_tmp)
        en_seen |-> (en_gap <= 8'(SYS_CLK_DIV)))
        else $error("sys_clk_en pulse missing");

endmodule

// ==== tests/tb_clocks_resets.sv ====
`timescale 1ns/100ps

module tb_clocks_resets;
    import crg_timing_pkg::*;

    localparam int NUM_TESTS      = 6;
    localparam int HALF_DIV       = SYS_CLK_DIV / 2;
    localparam int TIMEOUT_CYCLES =
        4 * (LOCK_CYCLES + (RST_SYNC_NUM + 2) * SYS_CLK_DIV) * NUM_TESTS;

    logic brd_clk_p;
    logic brd_rst;
    logic ddr_calib_done;
    logic sys_rst;
    logic sys_clk;
    logic clk_200;

    int          cycle_cnt = 0;
    int          calib_late;
    int          win_min;
    int          win_max;

    // Results waiting for the comparison process
    string res_name_q[$];
    int    res_min_q[$];
    int    res_max_q[$];
    int    res_act_q[$];

    clocks_resets i_clocks_resets (
        .i_brd_clk_p      (brd_clk_p),
        .i_brd_rst        (brd_rst),
        .i_ddr_calib_done (ddr_calib_done),
        .o_sys_rst        (sys_rst),
        .o_sys_clk        (sys_clk),
        .o_clk_200        (clk_200)
    );

    bind reset_ctrl crg_chk u_crg_chk (
        .i_brd_clk_p  (i_brd_clk_p),
        .i_rst_tmp    (rst_tmp),
        .i_sys_clk_en (crg.sys_clk_en),
        .i_calib_sync (crg.calib_sync),
        .i_sys_rst    (crg.sys_rst)
    );

    always #4 brd_clk_p = ~brd_clk_p;   // 8 ns board clock

    // ====================
    // Reference model
    // ====================
    // Cycles from a trigger to the o_sys_rst edge
    // lock_delay is 0 for calibration changes
    function automatic void expected_release_window(input int lock_delay, output int min_cyc,
                                                    output int max_cyc);
        min_cyc = lock_delay + (RST_SYNC_NUM - 1) * SYS_CLK_DIV;
        max_cyc = lock_delay + (RST_SYNC_NUM + 1) * SYS_CLK_DIV + 2;
    endfunction

    task automatic post_result(input string name, input int min_cyc, input int max_cyc,
                               input int actual);
        res_name_q.push_back(name);
        res_min_q.push_back(min_cyc);
        res_max_q.push_back(max_cyc);
        res_act_q.push_back(actual);
    endtask

    // Board reset for 2 cycles with outputs checked in reset right away
    task automatic pulse_board_reset(input string name);
        @(posedge brd_clk_p);
        brd_rst <= 1'b1;
        repeat (2)
        begin
            @(negedge brd_clk_p);
            post_result({name, " o_sys_rst"}, 1, 1, int'(sys_rst));
            post_result({name, " o_sys_clk"}, 0, 0, int'(sys_clk));
            @(posedge brd_clk_p);
        end
        brd_rst <= 1'b0;
    endtask

    // Counts cycles from the current edge until o_sys_rst reaches target
    task automatic measure_sys_rst(input string name, input int lock_delay, input logic target);
        int n;
        int mn;
        int mx;
        n = 0;
        expected_release_window(lock_delay, mn, mx);
        do
        begin
            @(posedge brd_clk_p);
            n = n + 1;
            @(negedge brd_clk_p);
            if (n <= lock_delay)
                post_result({name, " o_sys_clk before lock"}, 0, 0, int'(sys_clk));
        end
        while (sys_rst != target);
        post_result(name, mn, mx, n);
    endtask

    task automatic check_clock_shape(input string name, input int periods);
        int hi;
        int lo;
        do @(negedge brd_clk_p); while (sys_clk != 1'b0);
        do @(negedge brd_clk_p); while (sys_clk != 1'b1);   // First high sample
        repeat (periods)
        begin
            hi = 0;
            lo = 0;
            while (sys_clk == 1'b1)
            begin
                hi = hi + 1;
                @(negedge brd_clk_p);
            end
            while (sys_clk == 1'b0)
            begin
                lo = lo + 1;
                @(negedge brd_clk_p);
            end
            post_result({name, " high"}, HALF_DIV, HALF_DIV, hi);
            post_result({name, " low"}, HALF_DIV, HALF_DIV, lo);
        end
    endtask

    // ====================
    // Comparison
    // ====================
    always @(negedge brd_clk_p)
    begin : compare
        string name;
        int    mn;
        int    mx;
        int    act;
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run did not finish within %0d board cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $fatal(1, "Run stopped by the watchdog");
        end
        while (res_act_q.size() != 0)
        begin
            name = res_name_q.pop_front();
            mn   = res_min_q.pop_front();
            mx   = res_max_q.pop_front();
            act  = res_act_q.pop_front();
            assert (act >= mn && act <= mx)
            else
            begin
                $display("Mismatch %s: expected %0d..%0d, actual %0d", name, mn, mx, act);
                $display("TB FAILED");
                $fatal(1, "Stopped at first error");
            end
        end
    end

    // Board clock passthrough sampled just after each clock change
    always @(brd_clk_p)
    begin
        #1;
        assert (clk_200 === brd_clk_p)
        else
        begin
            $display("Mismatch clk_passthrough: expected %b, actual %b", brd_clk_p, clk_200);
            $display("TB FAILED");
            $fatal(1, "Stopped at first error");
        end
    end

    // ====================
    // Stimulus
    // ====================
    initial
    begin
        void'($urandom(32'h9555_fb9f));         // Seed the generator
        brd_clk_p = 1'b0;
        brd_rst        <= 1'b1;
        ddr_calib_done <= 1'b1;

        // Reset, release timing and clock shape with calibration already done
        pulse_board_reset("board_reset");
        measure_sys_rst("release", LOCK_CYCLES, 1'b0);
        check_clock_shape("sys_clk_shape", 4);

        // Calibration arrives late
        @(posedge brd_clk_p);
        ddr_calib_done <= 1'b0;
        pulse_board_reset("calib_gating");
        expected_release_window(LOCK_CYCLES, win_min, win_max);
        calib_late = 10 + int'($urandom % 51);
        repeat (win_max + calib_late)
        begin
            @(negedge brd_clk_p);
            post_result("calib_gating hold", 1, 1, int'(sys_rst));
        end
        @(posedge brd_clk_p);
        ddr_calib_done <= 1'b1;
        measure_sys_rst("calib_gating", 0, 1'b0);

        // Calibration lost during run, then restored
        repeat (5) @(posedge brd_clk_p);
        ddr_calib_done <= 1'b0;
        measure_sys_rst("calib_loss", 0, 1'b1);
        @(posedge brd_clk_p);
        ddr_calib_done <= 1'b1;
        measure_sys_rst("calib_restore", 0, 1'b0);

        // Board reset at a random point in run
        repeat (5 + int'($urandom % 36)) @(posedge brd_clk_p);
        pulse_board_reset("mid_run_reset");
        measure_sys_rst("mid_run_reset", LOCK_CYCLES, 1'b0);
        check_clock_shape("mid_run_sys_clk", 2);

        repeat (2) @(negedge brd_clk_p);    // Let the last results drain
        if (res_act_q.size() == 0)
        begin
            $display("TB PASSED");
            $finish;
        end
        else
        begin
            $display("TB FAILED");
            $fatal(1, "Results left unchecked");
        end
    end

endmodule

// ==== verilog.f ====
hdl/crg_timing_pkg.sv
hdl/crg_state_pkg.sv
hdl/crg_if.sv
hdl/sync_chain.sv
hdl/pll_model.sv
hdl/reset_ctrl.sv
hdl/clocks_resets.sv
tests/crg_chk.sv
tests/tb_clocks_resets.sv
